// File: access_align.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module access_align (
    input  logic           clk,
    input  logic           resetn,

    input  logic           cpu_req,
    input  logic           cpu_wr,
    input  lsu_pkg::size_e cpu_size,
    input  logic           cpu_signed,
    input  lsu_pkg::addr_t cpu_addr,
    input  lsu_pkg::word_t cpu_wdata,
    output logic           cpu_addr_ok,
    output logic           cpu_data_ok,
    output lsu_pkg::word_t cpu_rdata,

    output logic           m_req,
    output logic           m_wr,
    output lsu_pkg::addr_t m_addr,
    output lsu_pkg::strb_t m_strb,
    output lsu_pkg::word_t m_wdata,
    input  logic           m_addr_ok,
    input  logic           m_data_ok,
    input  lsu_pkg::word_t m_rdata
);
    import lsu_pkg::*;

    localparam int PEND_BITS = $clog2(`LSU_PENDING_LOADS);

    typedef logic [PEND_BITS-1:0] pend_ptr_t;

    offset_t   offset;
    logic      pend_full;
    logic      load_block;
    logic      accept;
    logic      push;
    logic      pop;
    word_t     lane;

    // descriptor queue, loads only.
    offset_t   off_q  [`LSU_PENDING_LOADS];
    size_e     size_q [`LSU_PENDING_LOADS];
    logic [`LSU_PENDING_LOADS-1:0] sign_q;
    pend_ptr_t wr_ptr;
    pend_ptr_t rd_ptr;
    logic [PEND_BITS:0] pend_cnt;

    function automatic pend_ptr_t next_ptr(input pend_ptr_t p);
        return (p == pend_ptr_t'(`LSU_PENDING_LOADS - 1)) ? '0 : pend_ptr_t'(p + 1'b1);
    endfunction

    assign offset     = cpu_addr[$bits(offset_t)-1:0];
    assign pend_full  = (pend_cnt == `LSU_PENDING_LOADS);
    assign load_block = !cpu_wr && pend_full;     // stores need no slot.

    assign m_req       = cpu_req && !load_block;
    assign m_wr        = cpu_wr;
    assign m_addr      = cpu_addr;
    assign cpu_addr_ok = m_addr_ok && !load_block;

    assign accept = m_req && m_addr_ok;
    assign push   = accept && !cpu_wr;
    // a store completes in its own accept cycle, never alongside a load.
    assign pop    = m_data_ok && !(accept && cpu_wr);

    assign cpu_data_ok = m_data_ok;

    // store lanes and strobe.
    always_comb begin
        case (cpu_size)
            size_byte: begin
                m_wdata = {(`LSU_DATA_WIDTH/8){cpu_wdata[7:0]}};
                m_strb  = strb_t'(1) << offset;
            end
            size_half: begin
                m_wdata = {(`LSU_DATA_WIDTH/16){cpu_wdata[15:0]}};
                m_strb  = strb_t'(2'b11) << {offset[1], 1'b0};
            end
            default: begin
                m_wdata = cpu_wdata;
                m_strb  = '1;
            end
        endcase
    end

    // load extraction, same cycle as m_data_ok.
    always_comb begin
        lane = m_rdata >> {off_q[rd_ptr], 3'b000};
        case (size_q[rd_ptr])
            size_byte: cpu_rdata = {{(`LSU_DATA_WIDTH-8){sign_q[rd_ptr] & lane[7]}}, lane[7:0]};
            size_half: cpu_rdata = {{(`LSU_DATA_WIDTH-16){sign_q[rd_ptr] & lane[15]}},
                                    lane[15:0]};
            default:   cpu_rdata = m_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            pend_cnt <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                pend_cnt <= pend_cnt + 1'b1;
            else if (pop && !push)
                pend_cnt <= pend_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            // halfwords ignore bit 0.
            off_q[wr_ptr]  <= (cpu_size == size_half) ? {offset[1], 1'b0} : offset;
            size_q[wr_ptr] <= cpu_size;
            sign_q[wr_ptr] <= cpu_signed;
        end
    end

    // every load completion from the buffer has a descriptor waiting.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (resetn)
        pop |-> pend_cnt != '0)
        else $error("load completion with no pending descriptor");

endmodule

// File: data_sram.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module data_sram (
    input  logic           clk,
    input  logic           resetn,

    input  logic           s_req,
    input  logic           s_wr,
    input  lsu_pkg::addr_t s_addr,
    input  lsu_pkg::strb_t s_strb,
    input  lsu_pkg::word_t s_wdata,
    output logic           s_addr_ok,
    output logic           s_data_ok,
    output lsu_pkg::word_t s_rdata
);
    import lsu_pkg::*;

    localparam int IDX_BITS = $clog2(`LSU_SRAM_WORDS);
    localparam int OFF_BITS = $bits(offset_t);
    localparam int CNT_BITS = $clog2(`LSU_SRAM_LATENCY + 1);

    typedef logic [IDX_BITS-1:0] sram_index_t;
    typedef logic [CNT_BITS-1:0] lat_cnt_t;

    // *********************************************************************
    // array and request tracking.
    // *********************************************************************

    word_t       mem [`LSU_SRAM_WORDS];
    sram_index_t index;
    logic        accept;

    logic        busy;          // one request outstanding.
    lat_cnt_t    lat_cnt;       // cycles left before data_ok.
    word_t       rdata_q;

    // upper bits beyond the depth wrap around.
    assign index  = s_addr[OFF_BITS +: IDX_BITS];
    assign accept = s_req && s_addr_ok;

    assign s_addr_ok = !busy;
    assign s_data_ok = busy && (lat_cnt == '0);
    assign s_rdata   = rdata_q;

    // *********************************************************************
    // latency counter.
    // *********************************************************************

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else begin
            if (accept) begin
                busy    <= 1'b1;
                lat_cnt <= lat_cnt_t'(`LSU_SRAM_LATENCY - 1);
            end else if (s_data_ok) begin
                busy <= 1'b0;           // response taken this edge.
            end else if (busy) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    // *********************************************************************
    // array access.
    // *********************************************************************

    // write lands on the accepting edge. read word held until data_ok.
    always_ff @(posedge clk) begin
        if (accept) begin
            if (s_wr) begin
                for (int b = 0; b < `LSU_DATA_WIDTH / 8; b++) begin
                    if (s_strb[b])
                        mem[index][8*b +: 8] <= s_wdata[8*b +: 8];
                end
            end
            rdata_q <= mem[index];
        end
    end

    // the buffer's bypass path must not forward an unknown address.
    a_req_addr_known: assert property (@(posedge clk) disable iff (resetn)
        s_req |-> !$isunknown(s_addr))
        else $error("sram request with unknown address");

endmodule

// File: flist.f
+incdir+.
lsu_pkg.sv
access_align.sv
load_store_buffer.sv
data_sram.sv
lsu_top.sv
lsu_tb.sv

// File: load_store_buffer.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module load_store_buffer (
    input  logic           clk,
    input  logic           resetn,

    // from the aligner.
    input  logic           m_req,
    input  logic           m_wr,
    input  lsu_pkg::addr_t m_addr,
    input  lsu_pkg::strb_t m_strb,
    input  lsu_pkg::word_t m_wdata,
    output logic           m_addr_ok,
    output logic           m_data_ok,
    output lsu_pkg::word_t m_rdata,

    // to the scratchpad.
    output logic           s_req,
    output logic           s_wr,
    output lsu_pkg::addr_t s_addr,
    output lsu_pkg::strb_t s_strb,
    output lsu_pkg::word_t s_wdata,
    input  logic           s_addr_ok,
    input  logic           s_data_ok,
    input  lsu_pkg::word_t s_rdata
);
    import lsu_pkg::*;

    // *********************************************************************
    // storage.
    // *********************************************************************

    buf_index_t head;       // push side.
    buf_index_t tail;       // oldest entry, the one in flight.

    logic [`LSU_BUFFER_DEPTH-1:0] free_q;   // slot holds nothing.
    logic [`LSU_BUFFER_DEPTH-1:0] req_q;    // entry still to be issued.

    logic  wr_q    [`LSU_BUFFER_DEPTH];
    addr_t addr_q  [`LSU_BUFFER_DEPTH];
    strb_t strb_q  [`LSU_BUFFER_DEPTH];
    word_t wdata_q [`LSU_BUFFER_DEPTH];

    logic fifo_empty;
    logic fifo_full;
    logic load_done;
    logic slot_ok;
    logic push;
    logic pop;
    logic issue;

    // entries leave in order, so a free tail means nothing is queued.
    assign fifo_empty = free_q[tail];
    assign fifo_full  = !free_q[head];

    assign pop       = !fifo_empty && s_data_ok;
    assign load_done = pop && !wr_q[tail];
    assign issue     = !fifo_empty && s_req && s_addr_ok;

    // a store ack and a load ack must not share one data_ok pulse.
    assign slot_ok = !fifo_full && !(m_wr && load_done);
    assign push    = m_req && (fifo_empty || slot_ok);

    // *********************************************************************
    // state updates.
    // *********************************************************************

    always_ff @(posedge clk) begin
        if (resetn) begin
            head   <= '0;
            tail   <= '0;
            free_q <= '1;
            req_q  <= '0;
        end else begin
            for (int i = 0; i < `LSU_BUFFER_DEPTH; i++) begin
                if (push && head == buf_index_t'(i)) begin
                    free_q[i] <= 1'b0;
                    req_q[i]  <= !(fifo_empty && s_addr_ok);   // bypassed already?
                end else begin
                    if (pop && tail == buf_index_t'(i))
                        free_q[i] <= 1'b1;
                    if (issue && tail == buf_index_t'(i))
                        req_q[i] <= 1'b0;                       // issue once.
                end
            end

            if (push)
                head <= buf_index_t'(head + 1'b1);
            if (pop)
                tail <= buf_index_t'(tail + 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            wr_q[head]    <= m_wr;
            addr_q[head]  <= m_addr;
            strb_q[head]  <= m_strb;
            wdata_q[head] <= m_wdata;
        end
    end

    // *********************************************************************
    // drivers.
    // *********************************************************************

    assign m_rdata = s_rdata;

    always_comb begin
        if (fifo_empty) begin
            s_req     = m_req;      // pass-through.
            s_wr      = m_wr;
            s_addr    = m_addr;
            s_strb    = m_strb;
            s_wdata   = m_wdata;
            m_addr_ok = 1'b1;
        end else begin
            s_req     = req_q[tail];
            s_wr      = wr_q[tail];
            s_addr    = addr_q[tail];
            s_strb    = strb_q[tail];
            s_wdata   = wdata_q[tail];
            m_addr_ok = push;
        end
    end

    // stores post on accept. loads wait for the sram.
    assign m_data_ok = (push && m_wr) || load_done;

    a_no_push_full: assert property (@(posedge clk) disable iff (resetn)
        fifo_full |-> !push)
        else $error("push into a full buffer");

    // sram may only answer an entry that was handed to it.
    a_data_ok_issued: assert property (@(posedge clk) disable iff (resetn)
        s_data_ok |-> !fifo_empty && !req_q[tail])
        else $error("sram data_ok with nothing issued");

endmodule

// File: lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// *************************************************************************
// data path.
// *************************************************************************

`define LSU_DATA_WIDTH 32       // word size in bits.
`define LSU_ADDR_WIDTH 32       // byte address.

// *************************************************************************
// buffering and scratchpad.
// *************************************************************************

// load/store buffer entries, power of two.
`define LSU_BUFFER_DEPTH 4

`define LSU_SRAM_WORDS 256      // power of two.
`define LSU_SRAM_LATENCY 2      // accept to data_ok, at least 1.

// load descriptors held by the aligner.
// no smaller than the buffer depth, or loads stall ahead of the buffer.
`define LSU_PENDING_LOADS 4

`endif

// File: lsu_patterns.txt
// op size sign addr wdata expect, all hex, one access per line.
// op bit 0 store, bit 1 no idle gap before it, bit 2 load value not checked, f ends the list.
4 2 0 00000100 00000000 00000000
1 2 0 00000010 12345678 00000000
2 2 0 00000010 00000000 12345678
1 2 0 00000020 a5a5a5a5 00000000
1 0 0 00000021 0000003c 00000000
0 2 0 00000020 00000000 a5a53ca5
0 0 1 00000020 00000000 ffffffa5
0 0 0 00000020 00000000 000000a5
0 0 1 00000021 00000000 0000003c
1 1 0 00000022 00008001 00000000
0 1 1 00000022 00000000 ffff8001
0 1 0 00000022 00000000 00008001
0 1 1 00000020 00000000 00003ca5
1 2 0 00000030 0f0f0f0f 00000000
1 1 0 00000030 0000fedc 00000000
0 1 1 00000030 00000000 fffffedc
0 0 0 00000033 00000000 0000000f
1 0 0 00000032 00000080 00000000
0 0 1 00000032 00000000 ffffff80
0 2 0 00000030 00000000 0f80fedc
// burst of loads with no idle cycles, fills the buffer.
0 2 0 00000010 00000000 12345678
2 2 0 00000020 00000000 80013ca5
2 2 0 00000030 00000000 0f80fedc
2 0 0 00000011 00000000 00000056
2 1 1 00000012 00000000 00001234
2 0 1 00000023 00000000 ffffff80
2 0 1 00000031 00000000 fffffffe
2 2 0 00000010 00000000 12345678
3 2 0 00000040 deadbeef 00000000
2 2 0 00000040 00000000 deadbeef
// upper address bits wrap, low bits ignored for a word.
0 2 0 00000410 00000000 12345678
0 2 0 00000013 00000000 12345678
3 0 0 00000043 00000011 00000000
2 0 0 00000043 00000000 00000011
2 2 0 00000040 00000000 11adbeef
4 2 0 00000200 00000000 00000000
f 0 0 00000000 00000000 00000000

// File: lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

    // *********************************************************************
    // widths with a meaning of their own.
    // *********************************************************************

    typedef logic [`LSU_DATA_WIDTH-1:0] word_t;
    typedef logic [`LSU_ADDR_WIDTH-1:0] addr_t;

    // one bit per byte lane.
    typedef logic [`LSU_DATA_WIDTH/8-1:0] strb_t;

    typedef logic [$clog2(`LSU_DATA_WIDTH/8)-1:0] offset_t;     // byte within word.

    typedef logic [$clog2(`LSU_BUFFER_DEPTH)-1:0] buf_index_t;  // fifo pointer.

    // access size as the cpu encodes it.
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_e;

endpackage

// File: lsu_tb.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int PAT_MAX    = 64;
    localparam int PAT_FIELDS = 6;     // op, size, sign, addr, wdata, expect.

    logic  clk;
    logic  resetn;
    logic  cpu_req;
    logic  cpu_wr;
    size_e cpu_size;
    logic  cpu_signed;
    addr_t cpu_addr;
    word_t cpu_wdata;
    logic  cpu_addr_ok;
    logic  cpu_data_ok;
    word_t cpu_rdata;

    logic [31:0] pat_mem [PAT_MAX*PAT_FIELDS];
    int          pat_count;
    int          pat_idx;
    int          cycle_count;
    int          cycle_limit;
    int unsigned lcg_state;
    int          gap;
    logic [31:0] drv_op;
    logic [31:0] drv_size;

    // scoreboard state.
    word_t       exp_q [$];
    logic        chk_q [$];
    int          accept_count;
    int          done_count;
    logic        store_acked;
    logic        stall_seen;
    logic [31:0] mon_op;
    word_t       mon_exp;
    logic        mon_chk;

    lsu_top uut (
        .clk         (clk),
        .resetn      (resetn),
        .cpu_req     (cpu_req),
        .cpu_wr      (cpu_wr),
        .cpu_size    (cpu_size),
        .cpu_signed  (cpu_signed),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .cpu_rdata   (cpu_rdata)
    );

    always #20 clk = ~clk;

    // *********************************************************************
    // helpers.
    // *********************************************************************

    function automatic logic [31:0] pat_field(input int idx, input int field);
        return pat_mem[idx*PAT_FIELDS + field];
    endfunction

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // *********************************************************************
    // timeout.
    // *********************************************************************

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
            abort_run();
        end
    end

    // *********************************************************************
    // monitor, sampled at the falling edge.
    // *********************************************************************

    always @(negedge clk) begin
        if (!resetn) begin
            store_acked = 1'b0;
            if (cpu_req && !cpu_addr_ok)
                stall_seen = 1'b1;
            if (cpu_req && cpu_addr_ok) begin
                if (accept_count >= pat_count) begin
                    $display("request accepted beyond the end of the pattern list");
                    abort_run();
                end
                mon_op = pat_field(accept_count, 0);
                if (cpu_wr) begin
                    check_flag(cpu_data_ok, 1'b1, "store ack in its accept cycle");
                    store_acked = 1'b1;
                end else begin
                    exp_q.push_back(pat_field(accept_count, 5));
                    chk_q.push_back(!mon_op[2]);
                end
                accept_count++;
            end
            if (cpu_data_ok && !store_acked) begin
                if (exp_q.size() == 0) begin
                    $display("cpu_data_ok raised with no load outstanding at %0t ns", $time);
                    abort_run();
                end
                mon_exp = exp_q.pop_front();
                mon_chk = chk_q.pop_front();
                if (mon_chk)
                    check_word(cpu_rdata, mon_exp, "load data");
            end
            if (cpu_data_ok)
                done_count++;       // every pulse, load or store.
        end
    end

    // *********************************************************************
    // stimulus.
    // *********************************************************************

    initial begin
        clk          = 1'b0;
        resetn       = 1'b1;
        cpu_req      = 1'b0;
        cpu_wr       = 1'b0;
        cpu_size     = size_word;
        cpu_signed   = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        cycle_count  = 0;
        accept_count = 0;
        done_count   = 0;
        stall_seen   = 1'b0;
        lcg_state    = 59246;

        $readmemh("lsu_patterns.txt", pat_mem);
        pat_count = 0;
        while (pat_count < PAT_MAX && pat_field(pat_count, 0) != 32'hf)
            pat_count++;
        if (pat_count == 0 || pat_count == PAT_MAX) begin
            $display("pattern file is missing, empty or has no end marker");
            abort_run();
        end
        cycle_limit = pat_count * (`LSU_BUFFER_DEPTH + 1) * (`LSU_SRAM_LATENCY + 1)
                      + 3 * pat_count + 100;

        repeat (2) @(posedge clk);
        resetn <= 1'b0;

        @(negedge clk);
        check_flag(cpu_data_ok, 1'b0, "cpu_data_ok after reset");
        check_flag(cpu_addr_ok, 1'b1, "cpu_addr_ok after reset");

        @(posedge clk);
        for (pat_idx = 0; pat_idx < pat_count; pat_idx++) begin
            drv_op    = pat_field(pat_idx, 0);
            drv_size  = pat_field(pat_idx, 1);
            lcg_state = lcg_next(lcg_state);
            gap       = drv_op[1] ? 0 : int'((lcg_state >> 16) % 4);  // bit 1 means back-to-back.
            if (gap != 0) begin
                cpu_req <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            cpu_req    <= 1'b1;
            cpu_wr     <= drv_op[0];
            cpu_size   <= size_e'(drv_size[1:0]);
            cpu_signed <= pat_field(pat_idx, 2) != 0;
            cpu_addr   <= addr_t'(pat_field(pat_idx, 3));
            cpu_wdata  <= word_t'(pat_field(pat_idx, 4));
            @(negedge clk);
            while (!cpu_addr_ok)        // hold until accepted.
                @(negedge clk);
            @(posedge clk);
        end
        cpu_req <= 1'b0;

        // drain outstanding loads, then look for stray acks.
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (`LSU_SRAM_LATENCY + 2) @(negedge clk);

        check_flag(accept_count == pat_count, 1'b1, "every pattern accepted once");
        check_flag(done_count == accept_count, 1'b1, "one data_ok per accepted request");
        check_flag(stall_seen, 1'b1, "cpu_addr_ok dropped under back-pressure");

        $display("sim passed");
        $finish;
    end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
    input  logic           clk,
    input  logic           resetn,

    input  logic           cpu_req,
    input  logic           cpu_wr,
    input  lsu_pkg::size_e cpu_size,
    input  logic           cpu_signed,
    input  lsu_pkg::addr_t cpu_addr,
    input  lsu_pkg::word_t cpu_wdata,
    output logic           cpu_addr_ok,
    output logic           cpu_data_ok,
    output lsu_pkg::word_t cpu_rdata
);
    import lsu_pkg::*;

    // aligner to buffer.
    logic  m_req;
    logic  m_wr;
    addr_t m_addr;
    strb_t m_strb;
    word_t m_wdata;
    logic  m_addr_ok;
    logic  m_data_ok;
    word_t m_rdata;

    // buffer to scratchpad.
    logic  s_req;
    logic  s_wr;
    addr_t s_addr;
    strb_t s_strb;
    word_t s_wdata;
    logic  s_addr_ok;
    logic  s_data_ok;
    word_t s_rdata;

    access_align u_align (
        .clk         (clk),
        .resetn      (resetn),
        .cpu_req     (cpu_req),
        .cpu_wr      (cpu_wr),
        .cpu_size    (cpu_size),
        .cpu_signed  (cpu_signed),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .cpu_rdata   (cpu_rdata),
        .m_req       (m_req),
        .m_wr        (m_wr),
        .m_addr      (m_addr),
        .m_strb      (m_strb),
        .m_wdata     (m_wdata),
        .m_addr_ok   (m_addr_ok),
        .m_data_ok   (m_data_ok),
        .m_rdata     (m_rdata)
    );

    load_store_buffer u_buffer (
        .clk       (clk),
        .resetn    (resetn),
        .m_req     (m_req),
        .m_wr      (m_wr),
        .m_addr    (m_addr),
        .m_strb    (m_strb),
        .m_wdata   (m_wdata),
        .m_addr_ok (m_addr_ok),
        .m_data_ok (m_data_ok),
        .m_rdata   (m_rdata),
        .s_req     (s_req),
        .s_wr      (s_wr),
        .s_addr    (s_addr),
        .s_strb    (s_strb),
        .s_wdata   (s_wdata),
        .s_addr_ok (s_addr_ok),
        .s_data_ok (s_data_ok),
        .s_rdata   (s_rdata)
    );

    data_sram u_sram (
        .clk       (clk),
        .resetn    (resetn),
        .s_req     (s_req),
        .s_wr      (s_wr),
        .s_addr    (s_addr),
        .s_strb    (s_strb),
        .s_wdata   (s_wdata),
        .s_addr_ok (s_addr_ok),
        .s_data_ok (s_data_ok),
        .s_rdata   (s_rdata)
    );

endmodule
